// ==== bench/issue_tb.sv ====
`timescale 1ns/10ps
`include "issue_settings.svh"

module issue_tb;

    localparam int N           = `ISSUE_NUM_SICS;
    localparam int ID_W        = `ISSUE_ID_WIDTH;
    localparam int NUM_PHY     = `ISSUE_NUM_PHY_REGS;
    localparam int TEST_CYCLES = 184;
    // twice the reset plus test length
    localparam int MAX_CYCLES  = 400;

    logic                     clk;
    logic                     rst_n;
    logic [31:0]              imem_addr;
    issue_pkg::instr_u        imem_data [N];
    logic [N-1:0]             sic_req;
    issue_pkg::redirect_t     redirect;
    issue_pkg::issue_packet_t packets [N];

    // program space 0x3000..0x3fff
    logic [31:0] imem [1024];

    // reference model state
    logic [31:0]              m_pc;
    logic [ID_W-1:0]          m_id;
    issue_pkg::phy_reg_t      m_rat [32];
    logic [NUM_PHY-1:0]       m_free;
    int                       m_used;
    logic                     m_jr_wait;
    logic [ID_W-1:0]          m_jr_id;
    logic                     jr_seen;
    issue_pkg::issue_packet_t exp_pkt [N];
    logic [31:0]              exp_addr;

    int          seed;
    int          mismatches;
    int          other_errs;
    int          cycles = 0;
    int          wait_cycles;
    logic [31:0] rnd;
    logic [N-1:0] req;

    issue_controller dut0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .sic_req   (sic_req),
        .redirect  (redirect),
        .packets   (packets)
    );

    always #5 clk = ~clk;

    // ============================================================
    // instruction memory
    // ============================================================
    function automatic logic [31:0] r_op(input logic [5:0] fn, input int rd, input int rs,
                                         input int rt);
        return {6'h00, 5'(rs), 5'(rt), 5'(rd), 5'h00, fn};
    endfunction

    function automatic logic [31:0] i_op(input logic [5:0] opc, input int rt, input int rs,
                                         input logic [15:0] imm);
        return {opc, 5'(rs), 5'(rt), imm};
    endfunction

    // sw whose fields come from the address
    function automatic logic [31:0] fill_word(input logic [31:0] a);
        return {6'h2b, a[6:2], a[11:7], a[31:16] ^ a[15:0]};
    endfunction

    function automatic logic [31:0] fetch(input logic [31:0] a);
        if (a[31:12] == 20'h00003) begin
            return imem[a[11:2]];
        end
        return fill_word(a);
    endfunction

    always_comb begin
        for (int k = 0; k < N; k++) begin
            imem_data[k] = fetch(imem_addr + 32'(4 * k));
        end
    end

    task automatic load_program();
        for (int i = 0; i < 1024; i++) begin
            imem[i] = fill_word(32'h3000 + 32'(4 * i));
        end
        // straight line, dependences inside groups and writes to r0
        imem[0]  = i_op(6'h0d, 1, 0, 16'h0005);
        imem[1]  = i_op(6'h0d, 2, 1, 16'h0003);
        imem[2]  = r_op(6'h21, 3, 1, 2);
        imem[3]  = i_op(6'h0d, 0, 3, 16'h0001);
        imem[4]  = i_op(6'h23, 4, 3, 16'h0000);
        imem[5]  = i_op(6'h2b, 4, 2, 16'h0004);
        imem[6]  = r_op(6'h23, 5, 4, 3);
        imem[7]  = r_op(6'h25, 1, 5, 1);
        imem[8]  = r_op(6'h24, 0, 1, 2);
        imem[9]  = i_op(6'h23, 6, 1, 16'h0008);
        imem[10] = r_op(6'h26, 7, 6, 5);
        imem[11] = r_op(6'h2a, 2, 7, 1);
        imem[12] = {6'h02, 26'(32'h3100 >> 2)};
        // jal into a block that reads r31, then jr
        imem[64]  = i_op(6'h0d, 8, 2, 16'h0010);
        imem[65]  = {6'h03, 26'(32'h3200 >> 2)};
        imem[128] = r_op(6'h21, 9, 31, 8);
        imem[129] = r_op(6'h08, 0, 31, 0);
        // enough writers to drain the free pool
        for (int k = 0; k < 36; k++) begin
            if (k % 3 == 2) begin
                imem[192 + k] = i_op(6'h2b, k % 8 + 1, 2, 16'(k));
            end else begin
                imem[192 + k] = i_op(6'h0d, 10 + k % 20, 9 + k % 20, 16'(k));
            end
        end
    endtask

    // ============================================================
    // reference model
    // ============================================================
    task automatic model_reset();
        m_pc      = `ISSUE_RESET_PC;
        m_id      = '0;
        m_free    = '0;
        m_used    = 0;
        m_jr_wait = 1'b0;
        m_jr_id   = '0;
        jr_seen   = 1'b0;
        for (int r = 0; r < 32; r++) begin
            m_rat[r] = issue_pkg::phy_reg_t'(r);
        end
        for (int pr = 32; pr < NUM_PHY; pr++) begin
            m_free[pr] = 1'b1;
        end
        for (int i = 0; i < N; i++) begin
            exp_pkt[i] = '0;
        end
        exp_addr = m_pc;
    endtask

    // expected packets and fetch address after the next rising edge
    function automatic void ref_step(input logic [N-1:0] rq, input issue_pkg::redirect_t rd);
        int                   slot;
        int                   pick;
        logic                 stop;
        logic                 wr;
        logic                 jump;
        logic [31:0]          target;
        logic [31:0]          w;
        logic [31:0]          spc;
        logic [4:0]           dst;
        issue_pkg::op_flags_t op;

        slot   = 0;
        jump   = 1'b0;
        target = '0;
        stop   = m_jr_wait;
        for (int i = 0; i < N; i++) begin
            exp_pkt[i] = '0;
        end
        if (m_jr_wait && rd.valid && rd.issue_id == m_jr_id) begin
            m_pc      = rd.pc;
            m_jr_wait = 1'b0;
        end
        for (int i = 0; i < N; i++) begin
            if (rq[i] && !stop) begin
                spc      = m_pc + 32'(4 * slot);
                w        = fetch(spc);
                op       = '0;
                op.alu_r = (w[31:26] == 6'h00) && (w[5:0] inside {[6'h20:6'h27], 6'h2a, 6'h2b});
                op.jr    = (w[31:26] == 6'h00) && (w[5:0] == 6'h08);
                op.ori   = (w[31:26] == 6'h0d);
                op.lui   = (w[31:26] == 6'h0f);
                op.lw    = (w[31:26] == 6'h23);
                op.sw    = (w[31:26] == 6'h2b);
                op.j     = (w[31:26] == 6'h02);
                op.jal   = (w[31:26] == 6'h03);
                dst  = op.alu_r ? w[15:11] : (op.jal ? 5'd31 : w[20:16]);
                wr   = (op.alu_r | op.ori | op.lui | op.lw | op.jal) && (dst != 5'd0);
                pick = 32;
                while (pick < NUM_PHY && !m_free[pick]) begin
                    pick++;
                end
                if (wr && pick == NUM_PHY) begin
                    // out of registers, group ends here
                    stop = 1'b1;
                end else begin
                    exp_pkt[i].valid    = 1'b1;
                    exp_pkt[i].pc       = spc;
                    exp_pkt[i].issue_id = m_id + ID_W'(slot);
                    exp_pkt[i].op       = op;
                    exp_pkt[i].instr    = w;
                    if (op.alu_r | op.ori | op.lw | op.sw | op.jr) begin
                        exp_pkt[i].phy_rs = m_rat[w[25:21]];
                    end
                    if (op.alu_r | op.sw) begin
                        exp_pkt[i].phy_rt = m_rat[w[20:16]];
                    end
                    if (wr) begin
                        m_free[pick]       = 1'b0;
                        m_rat[dst]         = issue_pkg::phy_reg_t'(pick);
                        exp_pkt[i].phy_dst = issue_pkg::phy_reg_t'(pick);
                        m_used++;
                    end
                    if (op.j | op.jal) begin
                        jump   = 1'b1;
                        target = {spc[31:28], w[25:0], 2'b00};
                        exp_pkt[i].next_pc_pred = target;
                    end else if (!op.jr) begin
                        exp_pkt[i].next_pc_pred = spc + 32'd4;
                    end
                    if (op.jr) begin
                        m_jr_wait = 1'b1;
                        m_jr_id   = m_id + ID_W'(slot);
                        jr_seen   = 1'b1;
                    end
                    slot++;
                    stop = op.j | op.jal | op.jr;
                end
            end
        end
        m_id = m_id + ID_W'(slot);
        if (jump) begin
            m_pc = target;
        end else if (!m_jr_wait) begin
            m_pc = m_pc + 32'(4 * slot);
        end
        exp_addr = m_pc;
    endfunction

    // ============================================================
    // checker, outputs settled after the rising edge
    // ============================================================
    always @(posedge clk) begin
        #2;
        assert (imem_addr == exp_addr)
            else begin
                $display("Mismatch imem_addr: expected %h, actual %h", exp_addr, imem_addr);
                mismatches++;
            end
        for (int i = 0; i < N; i++) begin
            assert (packets[i] == exp_pkt[i])
                else begin
                    $display("Mismatch packets[%0d]: expected %h, actual %h",
                             i, exp_pkt[i], packets[i]);
                    mismatches++;
                end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run still going after %0d cycles", cycles);
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        seed        = 32'h99f4;
        clk         = 1'b0;
        rst_n       = 1'b0;
        sic_req     = '0;
        redirect    = '0;
        mismatches  = 0;
        other_errs  = 0;
        wait_cycles = 0;
        model_reset();
        load_program();
        repeat (16) @(negedge clk);
        rst_n = 1'b1;

        for (int c = 0; c < TEST_CYCLES; c++) begin
            @(negedge clk);
            rnd = $random(seed);
            req = rnd[N-1:0];
            // full requests near the end of the pool
            if (m_used >= 24) begin
                req = '1;
            end
            redirect = '0;
            if (m_jr_wait) begin
                wait_cycles++;
                if (wait_cycles == 3) begin
                    redirect = '{valid: 1'b1, pc: 32'h3400, issue_id: m_jr_id + ID_W'(1)};
                end else if (wait_cycles == 6) begin
                    redirect = '{valid: 1'b1, pc: 32'h3300, issue_id: m_jr_id};
                end
            end
            sic_req = req;
            ref_step(req, redirect);
        end
        @(negedge clk);

        assert (m_used == 32)
            else begin
                $display("register pool was never exhausted, %0d allocations", m_used);
                other_errs++;
            end
        assert (jr_seen)
            else begin
                $display("no jr reached its wait state");
                other_errs++;
            end
        $display("%0d mismatches, %0d other errors", mismatches, other_errs);
        if (mismatches == 0 && other_errs == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== include/issue_settings.svh ====
`ifndef ISSUE_SETTINGS_SVH
`define ISSUE_SETTINGS_SVH

// ============================================================
// issue stage sizing
// ============================================================

// number of SICs, also the fetch block width in words
`define ISSUE_NUM_SICS 4

// physical register file size
// 0..31 hold the reset mapping, the rest are allocatable
`define ISSUE_NUM_PHY_REGS 64

// issue sequence number width
`define ISSUE_ID_WIDTH 16

// first fetch address after reset
`define ISSUE_RESET_PC 32'h0000_3000

`endif

// ==== issue_controller.f ====
+incdir+include
rtl/issue_pkg.sv
rtl/instr_decoder.sv
rtl/rename_table.sv
rtl/issue_sequencer.sv
rtl/issue_controller.sv
bench/issue_tb.sv

// ==== rtl/instr_decoder.sv ====
`timescale 1ns/10ps

module instr_decoder (
    input  issue_pkg::instr_u    word,
    output issue_pkg::dec_info_t info
);

    // primary opcodes
    localparam logic [5:0] OPC_SPECIAL = 6'h00;
    localparam logic [5:0] OPC_J       = 6'h02;
    localparam logic [5:0] OPC_JAL     = 6'h03;
    localparam logic [5:0] OPC_BEQ     = 6'h04;
    localparam logic [5:0] OPC_ORI     = 6'h0d;
    localparam logic [5:0] OPC_LUI     = 6'h0f;
    localparam logic [5:0] OPC_LW      = 6'h23;
    localparam logic [5:0] OPC_SW      = 6'h2b;

    // funct codes under SPECIAL
    localparam logic [5:0] FN_JR = 6'h08;

    issue_pkg::op_flags_t op;
    logic                 is_beq;
    logic [4:0]           dst;

    always_comb begin
        op = '0;
        if (word.r.opcode == OPC_SPECIAL) begin
            case (word.r.funct)
                FN_JR: op.jr = 1'b1;
                // add/addu/sub/subu/and/or/xor/nor
                6'h20, 6'h21, 6'h22, 6'h23,
                6'h24, 6'h25, 6'h26, 6'h27: op.alu_r = 1'b1;
                // slt/sltu
                6'h2a, 6'h2b: op.alu_r = 1'b1;
                default: op = '0;
            endcase
        end
        op.ori = (word.i.opcode == OPC_ORI);
        op.lui = (word.i.opcode == OPC_LUI);
        op.lw  = (word.i.opcode == OPC_LW);
        op.sw  = (word.i.opcode == OPC_SW);
        op.j   = (word.j.opcode == OPC_J);
        op.jal = (word.j.opcode == OPC_JAL);
    end

    // beq has no flag, it only reads its two sources
    assign is_beq = (word.i.opcode == OPC_BEQ);

    // destination field selection
    always_comb begin
        if (op.alu_r) begin
            dst = word.r.rd;
        end else if (op.jal) begin
            dst = 5'd31;
        end else begin
            dst = word.i.rt;
        end
    end

    always_comb begin
        info          = '0;
        info.op       = op;
        info.rs       = word.r.rs;
        info.rt       = word.r.rt;
        info.rs_used  = op.alu_r | op.ori | op.lw | op.sw | op.jr | is_beq;
        info.rt_used  = op.alu_r | op.sw | is_beq;
        info.dst_lr   = dst;
        // writes to r0 are dropped
        info.has_dst  = (op.alu_r | op.ori | op.lui | op.lw | op.jal) && (dst != 5'd0);
        info.target26 = word.j.target26;
    end

endmodule

// ==== rtl/issue_controller.sv ====
`timescale 1ns/10ps
`include "issue_settings.svh"

module issue_controller (
    input  logic                     clk,
    input  logic                     rst_n,
    output logic [31:0]              imem_addr,
    input  issue_pkg::instr_u        imem_data [`ISSUE_NUM_SICS],
    input  logic [`ISSUE_NUM_SICS-1:0] sic_req,
    input  issue_pkg::redirect_t     redirect,
    output issue_pkg::issue_packet_t packets [`ISSUE_NUM_SICS]
);

    localparam int N = `ISSUE_NUM_SICS;

    issue_pkg::dec_info_t slot_info [N];
    issue_pkg::slot_cnt_t slot_cand;
    issue_pkg::slot_cnt_t accept_cnt;
    issue_pkg::phy_reg_t  phy_rs [N];
    issue_pkg::phy_reg_t  phy_rt [N];
    issue_pkg::phy_reg_t  phy_dst [N];

    // one decoder per fetch slot
    for (genvar k = 0; k < N; k++) begin : g_dec
        instr_decoder dec (
            .word (imem_data[k]),
            .info (slot_info[k])
        );
    end

    rename_table rename0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .slot_info  (slot_info),
        .slot_cand  (slot_cand),
        .accept_cnt (accept_cnt),
        .phy_rs     (phy_rs),
        .phy_rt     (phy_rt),
        .phy_dst    (phy_dst)
    );

    issue_sequencer seq0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .sic_req    (sic_req),
        .slot_info  (slot_info),
        .words      (imem_data),
        .phy_rs     (phy_rs),
        .phy_rt     (phy_rt),
        .phy_dst    (phy_dst),
        .accept_cnt (accept_cnt),
        .redirect   (redirect),
        .slot_cand  (slot_cand),
        .pc         (imem_addr),
        .packets    (packets)
    );

endmodule

// ==== rtl/issue_pkg.sv ====
`include "issue_settings.svh"

package issue_pkg;

    typedef logic [$clog2(`ISSUE_NUM_PHY_REGS)-1:0] phy_reg_t;

    // count of slots in one group, 0 up to a full block
    typedef logic [$clog2(`ISSUE_NUM_SICS + 1)-1:0] slot_cnt_t;

    // ============================================================
    // instruction word views
    // ============================================================
    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } r_fmt_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm16;
    } i_fmt_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [25:0] target26;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        j_fmt_t j;
    } instr_u;

    typedef struct packed {
        logic alu_r;
        logic ori;
        logic lui;
        logic lw;
        logic sw;
        logic j;
        logic jal;
        logic jr;
    } op_flags_t;

    // one decoded fetch slot
    typedef struct packed {
        op_flags_t   op;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic        rs_used;
        logic        rt_used;
        logic        has_dst;
        logic [4:0]  dst_lr;
        logic [25:0] target26;
    } dec_info_t;

    typedef struct packed {
        logic                       valid;
        logic [31:0]                pc;
        logic [31:0]                next_pc_pred;
        logic [`ISSUE_ID_WIDTH-1:0] issue_id;
        op_flags_t                  op;
        instr_u                     instr;
        phy_reg_t                   phy_rs;
        phy_reg_t                   phy_rt;
        phy_reg_t                   phy_dst;
    } issue_packet_t;

    typedef struct packed {
        logic                       valid;
        logic [31:0]                pc;
        logic [`ISSUE_ID_WIDTH-1:0] issue_id;
    } redirect_t;

endpackage

// ==== rtl/issue_sequencer.sv ====
`timescale 1ns/10ps
`include "issue_settings.svh"

module issue_sequencer (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [`ISSUE_NUM_SICS-1:0] sic_req,
    input  issue_pkg::dec_info_t     slot_info [`ISSUE_NUM_SICS],
    input  issue_pkg::instr_u        words [`ISSUE_NUM_SICS],
    input  issue_pkg::phy_reg_t      phy_rs [`ISSUE_NUM_SICS],
    input  issue_pkg::phy_reg_t      phy_rt [`ISSUE_NUM_SICS],
    input  issue_pkg::phy_reg_t      phy_dst [`ISSUE_NUM_SICS],
    input  issue_pkg::slot_cnt_t     accept_cnt,
    input  issue_pkg::redirect_t     redirect,
    output issue_pkg::slot_cnt_t     slot_cand,
    output logic [31:0]              pc,
    output issue_pkg::issue_packet_t packets [`ISSUE_NUM_SICS]
);

    localparam int N    = `ISSUE_NUM_SICS;
    localparam int ID_W = `ISSUE_ID_WIDTH;

    logic [ID_W-1:0]          issue_id;
    logic                     jr_wait;
    logic [ID_W-1:0]          jr_id;

    logic [31:0]              slot_pc [N];
    logic [31:0]              slot_next [N];
    issue_pkg::slot_cnt_t     req_cnt;
    logic                     group_cut;
    logic                     jump_taken;
    logic                     jr_taken;
    logic [31:0]              jump_target;
    logic [ID_W-1:0]          jr_new_id;
    issue_pkg::issue_packet_t pkt_next [N];
    logic [N-1:0]             pkt_valid;

    // slot addresses and predicted successors
    always_comb begin
        for (int s = 0; s < N; s++) begin
            slot_pc[s] = pc + 32'(4 * s);
            if (slot_info[s].op.j || slot_info[s].op.jal) begin
                slot_next[s] = {slot_pc[s][31:28], slot_info[s].target26, 2'b00};
            end else if (slot_info[s].op.jr) begin
                slot_next[s] = '0;
            end else begin
                slot_next[s] = slot_pc[s] + 32'd4;
            end
        end
    end

    // ============================================================
    // group candidates: wanted slots, cut after the first jump
    // ============================================================
    always_comb begin
        req_cnt   = '0;
        slot_cand = '0;
        group_cut = 1'b0;
        for (int i = 0; i < N; i++) begin
            if (sic_req[i]) begin
                req_cnt = req_cnt + 1'b1;
            end
        end
        for (int s = 0; s < N; s++) begin
            if (!jr_wait && !group_cut && s < req_cnt) begin
                slot_cand = issue_pkg::slot_cnt_t'(s + 1);
                group_cut = slot_info[s].op.j | slot_info[s].op.jal | slot_info[s].op.jr;
            end
        end
    end

    // a jump can only be the last accepted slot
    always_comb begin
        jump_taken  = 1'b0;
        jr_taken    = 1'b0;
        jump_target = '0;
        jr_new_id   = issue_id;
        for (int s = 0; s < N; s++) begin
            if (s < accept_cnt) begin
                if (slot_info[s].op.j || slot_info[s].op.jal) begin
                    jump_taken  = 1'b1;
                    jump_target = slot_next[s];
                end
                if (slot_info[s].op.jr) begin
                    jr_taken  = 1'b1;
                    jr_new_id = issue_id + ID_W'(s);
                end
            end
        end
    end

    // requesting SICs take slots in ascending index
    always_comb begin
        int slot;

        slot = 0;
        for (int i = 0; i < N; i++) begin
            pkt_next[i] = '0;
            if (sic_req[i] && slot < accept_cnt) begin
                pkt_next[i].valid        = 1'b1;
                pkt_next[i].pc           = slot_pc[slot];
                pkt_next[i].next_pc_pred = slot_next[slot];
                pkt_next[i].issue_id     = issue_id + ID_W'(slot);
                pkt_next[i].op           = slot_info[slot].op;
                pkt_next[i].instr        = words[slot];
                pkt_next[i].phy_rs       = phy_rs[slot];
                pkt_next[i].phy_rt       = phy_rt[slot];
                pkt_next[i].phy_dst      = phy_dst[slot];
            end
            if (sic_req[i]) begin
                slot = slot + 1;
            end
        end
    end

    // fetch PC, id counter and the jr wait
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc       <= `ISSUE_RESET_PC;
            issue_id <= '0;
            jr_wait  <= 1'b0;
            jr_id    <= '0;
        end else if (jr_wait) begin
            if (redirect.valid && redirect.issue_id == jr_id) begin
                pc      <= redirect.pc;
                jr_wait <= 1'b0;
            end
        end else begin
            issue_id <= issue_id + ID_W'(accept_cnt);
            if (jump_taken) begin
                pc <= jump_target;
            end else if (jr_taken) begin
                jr_wait <= 1'b1;
                jr_id   <= jr_new_id;
            end else begin
                pc <= pc + 32'({accept_cnt, 2'b00});
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            packets <= '{default: '0};
        end else begin
            packets <= pkt_next;
        end
    end

    always_comb begin
        for (int i = 0; i < N; i++) begin
            pkt_valid[i] = packets[i].valid;
        end
    end

    // a cycle spent waiting on jr issues nothing at the next edge
    assert property (@(posedge clk) disable iff (!rst_n) jr_wait |=> (pkt_valid == '0))
        else $error("issue packet valid during jr wait");

endmodule

// ==== rtl/rename_table.sv ====
`timescale 1ns/10ps
`include "issue_settings.svh"

module rename_table (
    input  logic                  clk,
    input  logic                  rst_n,
    input  issue_pkg::dec_info_t  slot_info [`ISSUE_NUM_SICS],
    input  issue_pkg::slot_cnt_t  slot_cand,
    output issue_pkg::slot_cnt_t  accept_cnt,
    output issue_pkg::phy_reg_t   phy_rs [`ISSUE_NUM_SICS],
    output issue_pkg::phy_reg_t   phy_rt [`ISSUE_NUM_SICS],
    output issue_pkg::phy_reg_t   phy_dst [`ISSUE_NUM_SICS]
);

    localparam int N          = `ISSUE_NUM_SICS;
    localparam int NUM_PHY    = `ISSUE_NUM_PHY_REGS;
    localparam int FIRST_FREE = 32;

    issue_pkg::phy_reg_t rat [32];
    logic [NUM_PHY-1:0]  free_bitmap;

    // rolling copies for the current group
    issue_pkg::phy_reg_t rat_work [32];
    logic [NUM_PHY-1:0]  free_work;
    logic                alloc_fail;

    // ============================================================
    // in-order walk over the candidate slots
    // ============================================================
    always_comb begin
        issue_pkg::phy_reg_t pick;
        logic                found;

        rat_work   = rat;
        free_work  = free_bitmap;
        accept_cnt = slot_cand;
        alloc_fail = 1'b0;
        for (int s = 0; s < N; s++) begin
            // sources see every earlier slot of the group
            phy_rs[s]  = slot_info[s].rs_used ? rat_work[slot_info[s].rs] : '0;
            phy_rt[s]  = slot_info[s].rt_used ? rat_work[slot_info[s].rt] : '0;
            phy_dst[s] = '0;

            // lowest free register, scanned downward so the last hit wins
            pick  = '0;
            found = 1'b0;
            for (int pr = NUM_PHY - 1; pr >= FIRST_FREE; pr--) begin
                if (free_work[pr]) begin
                    pick  = issue_pkg::phy_reg_t'(pr);
                    found = 1'b1;
                end
            end

            if (s < slot_cand && !alloc_fail && slot_info[s].has_dst) begin
                if (found) begin
                    free_work[pick]                = 1'b0;
                    rat_work[slot_info[s].dst_lr] = pick;
                    phy_dst[s]                     = pick;
                end else begin
                    // group ends in front of this writer
                    alloc_fail = 1'b1;
                    accept_cnt = issue_pkg::slot_cnt_t'(s);
                end
            end
        end
    end

    // only accepted slots touched the working copies
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int r = 0; r < 32; r++) begin
                rat[r] <= issue_pkg::phy_reg_t'(r);
            end
            for (int pr = 0; pr < NUM_PHY; pr++) begin
                free_bitmap[pr] <= (pr >= FIRST_FREE);
            end
        end else begin
            rat         <= rat_work;
            free_bitmap <= free_work;
        end
    end

    // committed destinations come from the free pool and leave it
    for (genvar s = 0; s < N; s++) begin : g_alloc_chk
        assert property (@(posedge clk) disable iff (!rst_n)
            (s < accept_cnt && slot_info[s].has_dst)
            |-> (phy_dst[s] >= FIRST_FREE && free_bitmap[phy_dst[s]])
                ##1 !free_bitmap[$past(phy_dst[s])])
            else $error("slot %0d committed a register that was not free", s);
    end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build the issue stage testbench with Verilator, run it, then search the log
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module issue_tb \
    -f issue_controller.f -o issue_sim > build.log 2>&1 &&
{ ./obj_dir/issue_sim > sim.log 2>&1 || true; } &&
grep -q '^Simulation passed$' sim.log &&
echo "PASS" && exit 0 ||
{ echo "FAIL (see build.log and sim.log)"; exit 1; }
